/* Makefile */
# Verilator build for the glitch sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_glitch_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
glitch_pkg.sv
glitch_cfg_if.sv
glitch_regs.sv
trig_cond.sv
trigger_resync.sv
glitch_pulse.sv
glitch_top.sv
tb_glitch_top.sv

/* glitch_cfg_if.sv */
`timescale 1ns/1ps

interface glitch_cfg_if import glitch_pkg::*; #(
  parameter int pMAX_GLITCHES     = 8,
  parameter int pNUM_GLITCH_WIDTH = 4
) ();

  // configuration, owned by the register bank
  logic                         arm;
  logic [WB_DATA_W-1:0]         offset;
  logic [pNUM_GLITCH_WIDTH-1:0] num_glitches;
  glitch_width_t                width [pMAX_GLITCHES];

  // status, returned by the glitch core
  logic                         done_set;
  logic                         busy;
  logic [pNUM_GLITCH_WIDTH-1:0] glitch_count;

  // register bank side
  modport regs (
    output arm, offset, num_glitches, width,
    input  done_set, busy, glitch_count
  );

  // sequencer and pulse generator side
  modport core (
    input  arm, offset, num_glitches, width,
    output done_set, busy, glitch_count
  );

endinterface

/* glitch_pkg.sv */
package glitch_pkg;

  // wishbone word address and data widths
  localparam int WB_ADDR_W = 4;
  localparam int WB_DATA_W = 32;

  // glitch pulse width in clock cycles
  // a programmed width of zero is stretched to one cycle
  typedef logic [7:0] glitch_width_t;

  // register map, word addresses
  // ctrl: bit 0 arm, bit 1 written as one clears done
  localparam logic [WB_ADDR_W-1:0] REG_CTRL       = 4'd0;
  // trigger to glitch offset in cycles
  localparam logic [WB_ADDR_W-1:0] REG_OFFSET     = 4'd1;
  // number of glitches in a burst
  localparam logic [WB_ADDR_W-1:0] REG_NUM        = 4'd2;
  // status: bit 0 sticky done, bit 1 busy, bits 15:8 glitch count
  localparam logic [WB_ADDR_W-1:0] REG_STATUS     = 4'd3;
  // per-glitch widths, one word each from here upward
  localparam logic [WB_ADDR_W-1:0] REG_WIDTH_BASE = 4'd4;

  // burst sequencer states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    WAIT = 2'd1,
    NEXT = 2'd2,
    DONE = 2'd3
  } seq_state_t;

endpackage

/* glitch_pulse.sv */
`timescale 1ns/1ps

module glitch_pulse import glitch_pkg::*; #(
  parameter int pMAX_GLITCHES     = 8,
  parameter int pNUM_GLITCH_WIDTH = 4
) (
  input  logic                         clk,
  input  logic                         exttrig,
  input  logic                         fire,
  input  logic [pNUM_GLITCH_WIDTH-1:0] index,
  output logic                         glitch_out,
  output logic                         pulse_busy,
  glitch_cfg_if.core                   cfg
);

  glitch_width_t sel_width;
  glitch_width_t remaining;

  // width of the glitch being fired
  always_comb begin
    sel_width = '0;
    for (int i = 0; i < pMAX_GLITCHES; i++) begin
      if (index == pNUM_GLITCH_WIDTH'(i)) begin
        sel_width = cfg.width[i];
      end
    end
  end

  // back-pressure to the sequencer
  // covers the fire cycle and every cycle the output is high
  assign pulse_busy = fire | glitch_out;

  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      glitch_out       <= 1'b0;
      remaining        <= '0;
      cfg.glitch_count <= '0;
    end else if (fire) begin
      glitch_out <= 1'b1;
      // zero width behaves as one cycle
      remaining  <= (sel_width == '0) ? glitch_width_t'(1) : sel_width;
      // first glitch of a burst restarts the count
      if (index == '0) begin
        cfg.glitch_count <= '0;
      end
    end else if (glitch_out) begin
      remaining <= remaining - glitch_width_t'(1);
      // last high cycle, count the pulse as it falls
      if (remaining == glitch_width_t'(1)) begin
        glitch_out       <= 1'b0;
        cfg.glitch_count <= cfg.glitch_count + pNUM_GLITCH_WIDTH'(1);
      end
    end
  end

endmodule

/* glitch_regs.sv */
`timescale 1ns/1ps

module glitch_regs import glitch_pkg::*; #(
  parameter int pMAX_GLITCHES     = 8,
  parameter int pNUM_GLITCH_WIDTH = 4
) (
  input  logic                 clk,
  input  logic                 exttrig,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [WB_ADDR_W-1:0] wb_adr,
  input  logic [WB_DATA_W-1:0] wb_wdata,
  output logic [WB_DATA_W-1:0] wb_rdata,
  output logic                 wb_ack,
  glitch_cfg_if.regs           cfg
);

  logic                 done_q;
  logic                 wb_req;
  logic [WB_DATA_W-1:0] rd_mux;
  logic [WB_DATA_W-1:0] status_word;

  // new request: strobe seen and not already in its ack cycle
  // so ack is exactly one cycle long even if stb lingers
  assign wb_req = wb_cyc & wb_stb & ~wb_ack;

  // status word layout
  assign status_word = {16'd0, 8'(cfg.glitch_count), 6'd0, cfg.busy, done_q};

  // read mux
  always_comb begin
    rd_mux = '0;
    case (wb_adr)
      REG_CTRL:   rd_mux = {{(WB_DATA_W-1){1'b0}}, cfg.arm};
      REG_OFFSET: rd_mux = cfg.offset;
      REG_NUM:    rd_mux = WB_DATA_W'(cfg.num_glitches);
      REG_STATUS: rd_mux = status_word;
      default: begin
        // width window, unmapped words read as zero
        for (int i = 0; i < pMAX_GLITCHES; i++) begin
          if (wb_adr == WB_ADDR_W'(REG_WIDTH_BASE + i)) begin
            rd_mux = WB_DATA_W'(cfg.width[i]);
          end
        end
      end
    endcase
  end

  // bus handshake and register writes
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      wb_ack           <= 1'b0;
      wb_rdata         <= '0;
      cfg.arm          <= 1'b0;
      cfg.offset       <= '0;
      cfg.num_glitches <= '0;
      for (int i = 0; i < pMAX_GLITCHES; i++) begin
        cfg.width[i] <= '0;
      end
    end else begin
      wb_ack <= wb_req;
      // read data lands together with ack
      if (wb_req) begin
        wb_rdata <= rd_mux;
      end
      if (wb_req && wb_we) begin
        case (wb_adr)
          REG_CTRL:   cfg.arm <= wb_wdata[0];
          REG_OFFSET: cfg.offset <= wb_wdata;
          REG_NUM: begin
            // clamp so the glitch index never leaves the width table
            if (wb_wdata > WB_DATA_W'(pMAX_GLITCHES)) begin
              cfg.num_glitches <= pNUM_GLITCH_WIDTH'(pMAX_GLITCHES);
            end else begin
              cfg.num_glitches <= wb_wdata[pNUM_GLITCH_WIDTH-1:0];
            end
          end
          default: begin
            for (int i = 0; i < pMAX_GLITCHES; i++) begin
              if (wb_adr == WB_ADDR_W'(REG_WIDTH_BASE + i)) begin
                cfg.width[i] <= wb_wdata[7:0];
              end
            end
          end
        endcase
      end
    end
  end

  // sticky done
  // a completion in the same cycle as a clear write wins
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      done_q <= 1'b0;
    end else if (cfg.done_set) begin
      done_q <= 1'b1;
    end else if (wb_req && wb_we && (wb_adr == REG_CTRL) && wb_wdata[1]) begin
      done_q <= 1'b0;
    end
  end

endmodule

/* glitch_top.sv */
`timescale 1ns/1ps

module glitch_top import glitch_pkg::*; #(
  parameter int pMAX_GLITCHES     = 8,
  parameter int pNUM_GLITCH_WIDTH = 4,
  parameter int pSYNC_STAGES      = 2
) (
  input  logic                         clk,
  input  logic                         exttrig,
  // wishbone classic slave
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [WB_ADDR_W-1:0]         wb_adr,
  input  logic [WB_DATA_W-1:0]         wb_wdata,
  output logic [WB_DATA_W-1:0]         wb_rdata,
  output logic                         wb_ack,
  // trigger and glitch pins
  input  logic                         trig_in,
  output logic                         glitch_out,
  output logic [pNUM_GLITCH_WIDTH-1:0] glitch_index,
  output logic                         done
);

  logic trig_event;
  logic fire;
  logic idle;
  logic pulse_busy;

  // shared configuration and status
  glitch_cfg_if #(
    .pMAX_GLITCHES     (pMAX_GLITCHES),
    .pNUM_GLITCH_WIDTH (pNUM_GLITCH_WIDTH)
  ) cfg_if ();

  glitch_regs #(
    .pMAX_GLITCHES     (pMAX_GLITCHES),
    .pNUM_GLITCH_WIDTH (pNUM_GLITCH_WIDTH)
  ) i_regs (
    .clk      (clk),
    .exttrig  (exttrig),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .cfg      (cfg_if.regs)
  );

  // arm gating sees the sequencer idle flag
  trig_cond #(
    .pSYNC_STAGES (pSYNC_STAGES)
  ) i_trig_cond (
    .clk        (clk),
    .exttrig    (exttrig),
    .trig_in    (trig_in),
    .arm        (cfg_if.arm),
    .idle       (idle),
    .trig_event (trig_event)
  );

  trigger_resync #(
    .pNUM_GLITCH_WIDTH (pNUM_GLITCH_WIDTH)
  ) i_seq (
    .clk        (clk),
    .exttrig    (exttrig),
    .trig_event (trig_event),
    .pulse_busy (pulse_busy),
    .fire       (fire),
    .idle       (idle),
    .done       (done),
    .index      (glitch_index),
    .cfg        (cfg_if.core)
  );

  glitch_pulse #(
    .pMAX_GLITCHES     (pMAX_GLITCHES),
    .pNUM_GLITCH_WIDTH (pNUM_GLITCH_WIDTH)
  ) i_pulse (
    .clk        (clk),
    .exttrig    (exttrig),
    .fire       (fire),
    .index      (glitch_index),
    .glitch_out (glitch_out),
    .pulse_busy (pulse_busy),
    .cfg        (cfg_if.core)
  );

endmodule

/* tb_glitch_top.sv */
`timescale 1ns/1ps

module tb_glitch_top import glitch_pkg::*; ();

  localparam int MAX_GLITCHES = 8;
  localparam int NUM_W        = 4;
  localparam int SYNC_STAGES  = 2;
  localparam int POLL_LIMIT   = 20;
  localparam int BURST_LIMIT  = 5000;
  localparam logic [31:0] SEED = 32'h7327dba2;

  logic                 clk;
  logic                 exttrig;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [WB_ADDR_W-1:0] wb_adr;
  logic [WB_DATA_W-1:0] wb_wdata;
  logic [WB_DATA_W-1:0] wb_rdata;
  logic                 wb_ack;
  logic                 trig_in;
  logic                 glitch_out;
  logic [NUM_W-1:0]     glitch_index;
  logic                 done;

  // error counters
  int mismatches = 0;
  int failures   = 0;

  // cycle count and pulse bookkeeping for the monitor
  int   cyc        = 0;
  int   pulse_no   = 0;
  int   rise_cyc   = 0;
  int   last_fall  = 0;
  int   trig_cyc   = 0;
  int   done_count = 0;
  int   done_cyc   = 0;
  int   exp_offset = 0;
  int   exp_n      = 0;
  int   exp_width [MAX_GLITCHES];
  bit   pulses_expected = 1'b0;
  logic prev_glitch     = 1'b0;

  glitch_top #(
    .pMAX_GLITCHES     (MAX_GLITCHES),
    .pNUM_GLITCH_WIDTH (NUM_W),
    .pSYNC_STAGES      (SYNC_STAGES)
  ) i_dut (
    .clk          (clk),
    .exttrig      (exttrig),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_wdata     (wb_wdata),
    .wb_rdata     (wb_rdata),
    .wb_ack       (wb_ack),
    .trig_in      (trig_in),
    .glitch_out   (glitch_out),
    .glitch_index (glitch_index),
    .done         (done)
  );

  always #5 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // zero width stretches to one cycle
  function automatic int eff_width(input int w);
    return (w == 0) ? 1 : w;
  endfunction

  task automatic expect_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    failures++;
    $display("at %0t: %s", $time, msg);
  endtask

  // single classic cycle, ack polled just after each edge
  task automatic bus_cycle(input logic we, input logic [WB_ADDR_W-1:0] addr,
                           input logic [WB_DATA_W-1:0] wdata,
                           output logic [WB_DATA_W-1:0] rdata);
    int polls;
    polls = 0;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = addr;
    wb_wdata = wdata;
    do begin
      @(posedge clk);
      #1;
      polls++;
    end while (!wb_ack && polls < POLL_LIMIT);
    if (!wb_ack) begin
      report_failure("wishbone cycle timed out waiting for ack");
    end else begin
      expect_value("ack latency", 32'(polls), 32'd1);
    end
    rdata = wb_rdata;
    // master takes ack on the next edge, strobe still high there
    if (wb_ack) begin
      @(posedge clk);
      #1;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [WB_ADDR_W-1:0] addr, input logic [WB_DATA_W-1:0] data);
    logic [WB_DATA_W-1:0] unused;
    bus_cycle(1'b1, addr, data, unused);
  endtask

  task automatic wb_read(input logic [WB_ADDR_W-1:0] addr, output logic [WB_DATA_W-1:0] data);
    bus_cycle(1'b0, addr, '0, data);
  endtask

  task automatic check_readback();
    logic [WB_DATA_W-1:0] val;
    logic [WB_DATA_W-1:0] data;
    int                   i;
    wb_read(REG_STATUS, data);
    expect_value("status after reset", data, 32'd0);
    val = $urandom();
    wb_write(REG_OFFSET, val);
    wb_read(REG_OFFSET, data);
    expect_value("offset readback", data, val);
    val = 32'($urandom_range(0, MAX_GLITCHES));
    wb_write(REG_NUM, val);
    wb_read(REG_NUM, data);
    expect_value("count readback", data, val);
    for (i = 0; i < MAX_GLITCHES; i++) begin
      val = 32'($urandom_range(0, 255));
      wb_write(REG_WIDTH_BASE + WB_ADDR_W'(i), val);
      wb_read(REG_WIDTH_BASE + WB_ADDR_W'(i), data);
      expect_value("width readback", data, val);
    end
    wb_write(REG_CTRL, 32'd1);
    wb_read(REG_CTRL, data);
    expect_value("arm readback", data, 32'd1);
    wb_write(REG_CTRL, 32'd0);
  endtask

  // bit 1 of the ctrl write also clears any old done
  task automatic program_burst(input int n, input int offset, input bit arm);
    int i;
    exp_n      = n;
    exp_offset = offset;
    wb_write(REG_NUM, 32'(n));
    wb_write(REG_OFFSET, 32'(offset));
    for (i = 0; i < MAX_GLITCHES; i++) begin
      exp_width[i] = $urandom_range(0, 5);
      wb_write(REG_WIDTH_BASE + WB_ADDR_W'(i), 32'(exp_width[i]));
    end
    wb_write(REG_CTRL, {30'd0, 1'b1, arm});
  endtask

  task automatic pulse_trigger();
    @(posedge clk);
    #1;
    trig_in  = 1'b1;
    trig_cyc = cyc;
    repeat (3) @(posedge clk);
    #1 trig_in = 1'b0;
  endtask

  // one armed burst, optionally with a second trigger in the middle
  task automatic run_burst(input int n, input bit retrigger);
    int                   waited;
    int                   retrig_at;
    int                   done_before;
    bit                   retrig_sent;
    logic [WB_DATA_W-1:0] status;
    waited      = 0;
    retrig_at   = 0;
    retrig_sent = 1'b0;
    program_burst(n, $urandom_range(0, 10), 1'b1);
    pulse_no        = 0;
    pulses_expected = 1'b1;
    done_before     = done_count;
    pulse_trigger();
    // sequencer has left idle by the time this read is acked
    wb_read(REG_STATUS, status);
    expect_value("status busy during burst", 32'(status[1]), 32'd1);
    while (done_count == done_before && waited < BURST_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
      if (retrigger && !retrig_sent && pulse_no >= 1) begin
        trig_in     = 1'b1;
        retrig_sent = 1'b1;
        retrig_at   = waited;
      end else if (trig_in && waited >= retrig_at + 3) begin
        trig_in = 1'b0;
      end
    end
    trig_in = 1'b0;
    if (done_count == done_before) begin
      report_failure("burst never signalled done");
    end else begin
      expect_value("pulses before done", 32'(pulse_no), 32'(n));
      expect_value("done after last fall", 32'(done_cyc > last_fall), 32'd1);
    end
    // quiet time, any extra pulse is caught by the monitor
    repeat (40) @(posedge clk);
    #1;
    expect_value("pulses after quiet time", 32'(pulse_no), 32'(n));
    wb_read(REG_STATUS, status);
    expect_value("status done and busy", 32'(status[1:0]), 32'd1);
    expect_value("status glitch count", 32'(status[15:8]), 32'(n));
    wb_write(REG_CTRL, 32'd3);
    wb_read(REG_STATUS, status);
    expect_value("done after clear", 32'(status[0]), 32'd0);
  endtask

  task automatic expect_no_burst(input int n, input bit arm);
    int done_before;
    program_burst(n, 2, arm);
    pulses_expected = 1'b0;
    done_before     = done_count;
    pulse_trigger();
    repeat (40) @(posedge clk);
    #1;
    expect_value("done pulses without a burst", 32'(done_count - done_before), 32'd0);
  endtask

  // pulse monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (!exttrig) begin
      if (glitch_out && !prev_glitch) begin
        if (!pulses_expected || pulse_no >= exp_n) begin
          report_failure("glitch pulse seen without a valid armed trigger");
        end else begin
          expect_value("glitch index at rise", 32'(glitch_index), 32'(pulse_no));
          if (pulse_no == 0) begin
            expect_value("trigger to first rise", 32'(cyc - trig_cyc),
                         32'(1 + exp_offset + SYNC_STAGES + 3));
          end else begin
            expect_value("fall to next rise", 32'(cyc - last_fall), 32'(exp_offset + 3));
          end
        end
        rise_cyc = cyc;
      end
      if (!glitch_out && prev_glitch) begin
        if (pulses_expected && pulse_no < exp_n) begin
          expect_value("pulse width", 32'(cyc - rise_cyc), 32'(eff_width(exp_width[pulse_no])));
        end
        last_fall = cyc;
        pulse_no++;
      end
      if (done) begin
        done_count++;
        done_cyc = cyc;
      end
    end
    prev_glitch = glitch_out;
  end

  ack_single: assert property (@(posedge clk) disable iff (exttrig) wb_ack |=> !wb_ack)
    else begin
      mismatches++;
      $display("mismatch at %0t: wb_ack high for more than one cycle", $time);
    end

  done_single: assert property (@(posedge clk) disable iff (exttrig) done |=> !done)
    else begin
      mismatches++;
      $display("mismatch at %0t: done high for more than one cycle", $time);
    end

  index_stable: assert property (@(posedge clk) disable iff (exttrig)
                                 glitch_out |-> $stable(glitch_index))
    else begin
      mismatches++;
      $display("mismatch at %0t: glitch_index moved during a pulse", $time);
    end

  // mid-cycle, after the first edge has applied the reset
  reset_quiet: assert property (@(negedge clk) exttrig |-> !glitch_out && !done && !wb_ack)
    else begin
      mismatches++;
      $display("mismatch at %0t: outputs not low in reset", $time);
    end

  initial begin
    int b;
    clk      = 1'b0;
    exttrig  = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_wdata = '0;
    trig_in  = 1'b0;
    void'($urandom(SEED));
    repeat (4) @(posedge clk);
    #1 exttrig = 1'b0;
    expect_value("glitch_out after reset", 32'(glitch_out), 32'd0);
    expect_value("done after reset", 32'(done), 32'd0);
    expect_value("wb_ack after reset", 32'(wb_ack), 32'd0);
    check_readback();
    for (b = 0; b < 5; b++) begin
      run_burst($urandom_range(1, MAX_GLITCHES), 1'b0);
    end
    run_burst(MAX_GLITCHES, 1'b0);
    // a trigger during a running burst is dropped
    run_burst(3, 1'b1);
    expect_no_burst(3, 1'b0);
    expect_no_burst(0, 1'b1);
    $display("error counts: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* trig_cond.sv */
`timescale 1ns/1ps

module trig_cond #(
  parameter int pSYNC_STAGES = 2
) (
  input  logic clk,
  input  logic exttrig,
  input  logic trig_in,
  input  logic arm,
  input  logic idle,
  output logic trig_event
);

  logic [pSYNC_STAGES-1:0] sync_q;
  logic                    edge_q;
  logic                    trig_rise;

  // trigger pin is asynchronous to clk
  // first stage may go metastable, later stages settle it
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= trig_in;
      for (int i = 1; i < pSYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // rising edge of the synchronized pin
  assign trig_rise = sync_q[pSYNC_STAGES-1] & ~edge_q;

  // edge register and gated event
  // an edge while disarmed or mid-burst is simply dropped
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      edge_q     <= 1'b0;
      trig_event <= 1'b0;
    end else begin
      edge_q     <= sync_q[pSYNC_STAGES-1];
      trig_event <= trig_rise & arm & idle;
    end
  end

endmodule

/* trigger_resync.sv */
`timescale 1ns/1ps

module trigger_resync import glitch_pkg::*; #(
  parameter int pNUM_GLITCH_WIDTH = 4
) (
  input  logic                         clk,
  input  logic                         exttrig,
  input  logic                         trig_event,
  // pulse generator has a pulse pending or high
  input  logic                         pulse_busy,
  output logic                         fire,
  output logic                         idle,
  output logic                         done,
  output logic [pNUM_GLITCH_WIDTH-1:0] index,
  glitch_cfg_if.core                   cfg
);

  seq_state_t           state;
  logic [WB_DATA_W-1:0] delay_cnt;
  logic                 offset_hit;
  logic                 last_glitch;

  // offset reached while waiting
  assign offset_hit = (state == WAIT) && (delay_cnt == cfg.offset);

  // current index is the final glitch of the burst
  assign last_glitch = (index == (cfg.num_glitches - pNUM_GLITCH_WIDTH'(1)));

  assign idle = (state == IDLE);

  // status reports the whole burst, not just the pulse
  assign cfg.busy = ~idle;

  // one-cycle completion strobe into the register bank
  assign cfg.done_set = done;

  // offset counter
  // starts at zero on every entry to WAIT
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      delay_cnt <= '0;
    end else if ((state == WAIT) && !offset_hit) begin
      delay_cnt <= delay_cnt + 32'd1;
    end else begin
      delay_cnt <= '0;
    end
  end

  // burst sequencer
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      state <= IDLE;
      fire  <= 1'b0;
      done  <= 1'b0;
      index <= '0;
    end else begin
      // fire goes out the cycle after the offset match
      fire <= offset_hit;
      done <= 1'b0;
      case (state)
        IDLE: begin
          index <= '0;
          // an empty burst never leaves idle
          if (trig_event && (cfg.num_glitches != '0)) begin
            state <= WAIT;
          end
        end
        WAIT: begin
          if (offset_hit) begin
            state <= last_glitch ? DONE : NEXT;
          end
        end
        NEXT: begin
          // hold until the current pulse has ended
          // fire itself keeps busy high on the first cycle here
          if (!pulse_busy) begin
            index <= index + pNUM_GLITCH_WIDTH'(1);
            state <= WAIT;
          end
        end
        DONE: begin
          // count can be stale from the previous burst until the
          // last fire is taken, so also wait for the pulse to clear
          if (!pulse_busy && (cfg.glitch_count == cfg.num_glitches)) begin
            done  <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule
